/* src.f */
hdl/ooo_decode_pkg.sv
hdl/control_unit.sv
hdl/imm_gen.sv
hdl/reg_file.sv
hdl/dispatch_latch.sv
hdl/ooo_decode_top.sv
tests/ooo_decode_assert.sv
tests/tb_ooo_decode_top.sv

/* tests/tb_ooo_decode_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_ooo_decode_top import ooo_decode_pkg::*; ();

  localparam int TIMEOUT = 50;

  logic            CLK;
  logic            nRST;
  logic            fetch_valid;
  fetch_decode_t   fetch;
  logic            decode_ready;
  logic            ex_stall;
  logic            ex_flush;
  wb_t             wb;
  logic            iflush_done;
  logic            dflush_done;
  logic            icache_flush;
  logic            dcache_flush;
  decode_execute_t de_out;

  // Reference model of the register file and slot counter
  word_t   model_regs [32];
  logic    model_busy [32];
  cb_idx_t model_cb;
  cb_idx_t exp_cb;

  int      errors;
  int      checks;
  word_t   lcg_state;
  logic    ready_during_wb;

  ooo_decode_top i_dut (
    .CLK          (CLK),
    .nRST         (nRST),
    .fetch_valid  (fetch_valid),
    .fetch        (fetch),
    .decode_ready (decode_ready),
    .ex_stall     (ex_stall),
    .ex_flush     (ex_flush),
    .wb           (wb),
    .iflush_done  (iflush_done),
    .dflush_done  (dflush_done),
    .icache_flush (icache_flush),
    .dcache_flush (dcache_flush),
    .de_out       (de_out)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Instruction encoders
  function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                  input reg_idx_t rs1, input logic [2:0] f3,
                                  input reg_idx_t rd, input opcode_t op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_i(input logic [11:0] v, input reg_idx_t rs1,
                                  input logic [2:0] f3, input reg_idx_t rd,
                                  input opcode_t op);
    return {v, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_s(input logic [11:0] v, input reg_idx_t rs2,
                                  input reg_idx_t rs1, input logic [2:0] f3);
    return {v[11:5], rs2, rs1, f3, v[4:0], OP_STORE};
  endfunction

  function automatic word_t enc_u(input logic [19:0] v, input reg_idx_t rd,
                                  input opcode_t op);
    return {v, rd, op};
  endfunction

  function automatic word_t enc_j(input logic [20:0] v, input reg_idx_t rd);
    return {v[20], v[10:1], v[11], v[19:12], rd, OP_JAL};
  endfunction

  function automatic word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic word_t sext21(input logic [20:0] v);
    return {{11{v[20]}}, v};
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_record(input sfu_type_t sfu, input word_t a, input word_t b);
    check_word("de_out.valid", 32'(de_out.valid), 32'd1);
    check_word("de_out.sfu_type", 32'(de_out.sfu_type), 32'(sfu));
    check_word("de_out.cb_index", 32'(de_out.cb_index), 32'(exp_cb));
    check_word("de_out.port_a", de_out.port_a, a);
    check_word("de_out.port_b", de_out.port_b, b);
  endtask

  task automatic present(input word_t instr, input word_t pc);
    fetch.instr = instr;
    fetch.pc    = pc;
    fetch.pc4   = pc + 32'd4;
    fetch_valid = 1'b1;
  endtask

  // Waits for the handshake, then books the slot and busy bit
  task automatic wait_accept(input reg_idx_t rd);
    int t;
    t = 0;
    #1;
    while (!decode_ready) begin
      t++;
      if (t > TIMEOUT) begin
        $display("Timed out waiting for decode_ready to accept an instruction");
        errors++;
        disable stimulus;
      end
      @(negedge CLK);
      #1;
    end
    @(negedge CLK);
    fetch_valid = 1'b0;
    exp_cb      = model_cb;
    model_cb    = cb_idx_t'((model_cb + 1) % CB_DEPTH);
    if (rd != '0) begin
      model_busy[rd] = 1'b1;
    end
  endtask

  task automatic send(input word_t instr, input word_t pc, input reg_idx_t rd);
    present(instr, pc);
    wait_accept(rd);
  endtask

  task automatic writeback(input reg_idx_t rd, input word_t data);
    wb.en   = 1'b1;
    wb.rd   = rd;
    wb.data = data;
    #1;
    ready_during_wb = decode_ready;
    @(negedge CLK);
    wb.en          = 1'b0;
    model_regs[rd] = data;
    model_busy[rd] = 1'b0;
  endtask

  initial begin
    begin : stimulus
      int              i;
      int              n;
      word_t           r;
      word_t           instr;
      word_t           exp_b;
      logic [11:0]     imm12;
      logic [20:0]     joff;
      logic [4:0]      sh;
      reg_idx_t        rs_a;
      reg_idx_t        rs_b;
      reg_idx_t        rd_r;
      sfu_type_t       sfu;
      decode_execute_t saved;

      errors      = 0;
      checks      = 0;
      lcg_state   = 32'h50b0;
      model_cb    = '0;
      exp_cb      = '0;
      nRST        = 1'b0;
      fetch_valid = 1'b0;
      fetch       = '0;
      ex_stall    = 1'b0;
      ex_flush    = 1'b0;
      wb          = '0;
      iflush_done = 1'b0;
      dflush_done = 1'b0;
      for (i = 0; i < 32; i++) begin
        model_regs[i] = '0;
        model_busy[i] = 1'b0;
      end

      repeat (8) @(negedge CLK);
      check_word("de_out.valid", 32'(de_out.valid), 32'd0);
      check_word("decode_ready", 32'(decode_ready), 32'd0);
      check_word("icache_flush", 32'(icache_flush), 32'd0);
      nRST = 1'b1;

      // Preload sources through the writeback port
      writeback(5'd1, lcg_next());
      check_word("decode_ready", 32'(decode_ready), 32'd1);
      for (i = 2; i < 5; i++) begin
        writeback(reg_idx_t'(i), lcg_next());
      end
      writeback(5'd18, lcg_next());

      // ADDI, SW, SLLI
      r     = lcg_next();
      imm12 = r[11:0];
      sh    = r[16:12];
      send(enc_i(imm12, 5'd1, 3'b000, 5'd11, OP_IMM), 32'h100, 5'd11);
      check_record(ARITH_S, model_regs[1], sext12(imm12));
      check_word("de_out.rd", 32'(de_out.rd), 32'd11);
      send(enc_s(imm12, 5'd2, 5'd1, 3'b010), 32'h104, 5'd0);
      check_record(LOADSTORE_S, sext12(imm12), model_regs[1]);
      send(enc_i({7'd0, sh}, 5'd3, 3'b001, 5'd12, OP_IMM), 32'h108, 5'd12);
      check_record(ARITH_S, model_regs[3], {27'd0, sh});
      check_word("de_out.rd", 32'(de_out.rd), 32'd12);

      // SRAI has bit 30 set in its immediate field
      send(enc_i({7'b0100000, sh}, 5'd4, 3'b101, 5'd7, OP_IMM), 32'h180, 5'd7);
      check_record(ARITH_S, model_regs[4], {27'd0, sh});
      check_word("de_out.alu_op", 32'(de_out.alu_op), 32'(ALU_SRA));

      // LUI, JAL, JALR
      r = lcg_next();
      send(enc_u(r[31:12], 5'd13, OP_LUI), 32'h10c, 5'd13);
      check_word("de_out.reg_file_wdata", de_out.reg_file_wdata, {r[31:12], 12'h000});
      joff = {r[20:1], 1'b0};
      send(enc_j(joff, 5'd14), 32'h200, 5'd14);
      check_word("de_out.reg_file_wdata", de_out.reg_file_wdata, 32'h204);
      check_word("de_out.j_base", de_out.j_base, 32'h200);
      check_word("de_out.j_offset", de_out.j_offset, sext21(joff));
      send(enc_i(imm12, 5'd2, 3'b000, 5'd15, OP_JALR), 32'h300, 5'd15);
      check_word("de_out.j_base", de_out.j_base, model_regs[2]);
      check_word("de_out.j_offset", de_out.j_offset, sext12(imm12));

      // RAW hazard on x5 through rs1, then through rs2
      for (n = 0; n < 2; n++) begin
        rs_a = (n == 0) ? 5'd5 : 5'd2;
        rs_b = (n == 0) ? 5'd2 : 5'd5;
        send(enc_i(imm12, 5'd1, 3'b000, 5'd5, OP_IMM), 32'h400 + 32'(n * 8), 5'd5);
        present(enc_r(7'd0, rs_b, rs_a, 3'b000, 5'd6, OP_REG), 32'h404 + 32'(n * 8));
        for (i = 0; i < 3; i++) begin
          #1;
          check_word("decode_ready", 32'(decode_ready), 32'(!model_busy[5]));
          @(negedge CLK);
        end
        writeback(5'd5, lcg_next());
        check_word("decode_ready", 32'(ready_during_wb), 32'd0);
        #1;
        check_word("decode_ready", 32'(decode_ready), 32'd1);
        wait_accept(5'd6);
        check_record(ARITH_S, model_regs[rs_a], model_regs[rs_b]);
      end

      // Random MUL, DIV, LW and ADD run across the slot wrap
      for (i = 0; i < 20; i++) begin
        r     = lcg_next();
        rs_a  = reg_idx_t'(r[1:0]) + 5'd1;
        rs_b  = reg_idx_t'(r[3:2]) + 5'd1;
        rd_r  = 5'd20 + reg_idx_t'(r[6:4]);
        exp_b = model_regs[rs_b];
        case (r[9:8])
          2'd0: begin
            instr = enc_r(7'd1, rs_b, rs_a, 3'b000, rd_r, OP_REG);
            sfu   = MUL_S;
          end
          2'd1: begin
            instr = enc_r(7'd1, rs_b, rs_a, 3'b100, rd_r, OP_REG);
            sfu   = DIV_S;
          end
          2'd2: begin
            instr = enc_i(r[31:20], rs_a, 3'b010, rd_r, OP_LOAD);
            sfu   = LOADSTORE_S;
            exp_b = sext12(r[31:20]);
          end
          default: begin
            instr = enc_r(7'd0, rs_b, rs_a, 3'b000, rd_r, OP_REG);
            sfu   = ARITH_S;
          end
        endcase
        send(instr, 32'h1000 + 32'(i * 4), rd_r);
        check_record(sfu, model_regs[rs_a], exp_b);
        check_word("de_out.rd", 32'(de_out.rd), 32'(rd_r));
      end

      // Back-pressure holds the record
      send(enc_i(imm12, 5'd1, 3'b000, 5'd16, OP_IMM), 32'h500, 5'd16);
      saved    = de_out;
      ex_stall = 1'b1;
      present(enc_r(7'd0, 5'd2, 5'd1, 3'b000, 5'd17, OP_REG), 32'h504);
      for (i = 0; i < 3; i++) begin
        #1;
        check_word("decode_ready", 32'(decode_ready), 32'd0);
        @(negedge CLK);
        checks++;
        assert (de_out === saved) else begin
          errors++;
          $display("[FAIL] de_out got 0x%h expected 0x%h", de_out, saved);
        end
      end
      ex_stall = 1'b0;
      wait_accept(5'd17);
      check_record(ARITH_S, model_regs[1], model_regs[2]);

      // Flushed instruction leaves no slot and no busy bit
      present(enc_i(imm12, 5'd1, 3'b000, 5'd18, OP_IMM), 32'h508);
      ex_flush = 1'b1;
      #1;
      check_word("decode_ready", 32'(decode_ready), 32'd1);
      @(negedge CLK);
      ex_flush    = 1'b0;
      fetch_valid = 1'b0;
      check_word("de_out.valid", 32'(de_out.valid), 32'd0);
      present(enc_r(7'd0, 5'd2, 5'd18, 3'b000, 5'd19, OP_REG), 32'h50c);
      #1;
      check_word("decode_ready", 32'(decode_ready), 32'(!model_busy[18]));
      wait_accept(5'd19);
      check_record(ARITH_S, model_regs[18], model_regs[2]);

      // Two fences, done pulses in opposite order
      for (n = 0; n < 2; n++) begin
        send(32'h0000_100f, 32'h600 + 32'(n * 16), 5'd0);
        check_word("icache_flush", 32'(icache_flush), 32'd1);
        check_word("dcache_flush", 32'(dcache_flush), 32'd1);
        present(enc_i(imm12, 5'd1, 3'b000, 5'd21, OP_IMM), 32'h604 + 32'(n * 16));
        #1;
        check_word("decode_ready", 32'(decode_ready), 32'd0);
        @(negedge CLK);
        check_word("icache_flush", 32'(icache_flush), 32'd0);
        check_word("dcache_flush", 32'(dcache_flush), 32'd0);
        iflush_done = (n == 0);
        dflush_done = (n != 0);
        #1;
        check_word("decode_ready", 32'(decode_ready), 32'd0);
        @(negedge CLK);
        iflush_done = (n != 0);
        dflush_done = (n == 0);
        #1;
        check_word("decode_ready", 32'(decode_ready), 32'd0);
        @(negedge CLK);
        iflush_done = 1'b0;
        dflush_done = 1'b0;
        wait_accept(5'd21);
        check_record(ARITH_S, model_regs[1], sext12(imm12));
      end
    end

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/ooo_decode_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module ooo_decode_assert import ooo_decode_pkg::*; (
  input logic            CLK,
  input logic            nRST,
  input logic            fetch_valid,
  input logic            decode_ready,
  input logic            ex_stall,
  input logic            ex_flush,
  input logic            icache_flush,
  input logic            dcache_flush,
  input decode_execute_t de_out
);

  // Everything quiet while reset is held
  reset_quiet: assert property (@(posedge CLK)
    !nRST |-> !de_out.valid && !decode_ready && !icache_flush && !dcache_flush)
    else $error("Outputs active during reset");

  stall_holds: assert property (@(posedge CLK) disable iff (!nRST)
    ex_stall && !ex_flush |=> $stable(de_out))
    else $error("Decode/execute record changed under back-pressure");

  flush_clears: assert property (@(posedge CLK) disable iff (!nRST)
    ex_flush |=> !de_out.valid)
    else $error("Record still valid after a flush");

  accept_valid: assert property (@(posedge CLK) disable iff (!nRST)
    fetch_valid && decode_ready && !ex_flush |=> de_out.valid)
    else $error("Accepted instruction did not show up as valid");

  // Flush request lasts one cycle
  flush_pulse: assert property (@(posedge CLK) disable iff (!nRST)
    icache_flush |=> !icache_flush)
    else $error("Cache flush request longer than one cycle");

  fence_blocks: assert property (@(posedge CLK) disable iff (!nRST)
    icache_flush |-> !decode_ready)
    else $error("Decode ready while a fence is flushing");

endmodule

bind dispatch_latch ooo_decode_assert u_ooo_decode_assert (
  .CLK          (CLK),
  .nRST         (nRST),
  .fetch_valid  (fetch_valid),
  .decode_ready (decode_ready),
  .ex_stall     (ex_stall),
  .ex_flush     (ex_flush),
  .icache_flush (icache_flush),
  .dcache_flush (dcache_flush),
  .de_out       (de_out)
);

`default_nettype wire

/* hdl/ooo_decode_top.sv */
`timescale 1ns/10ps
`default_nettype none

module ooo_decode_top import ooo_decode_pkg::*; (
  input  logic            CLK,
  input  logic            nRST,
  input  logic            fetch_valid,
  input  fetch_decode_t   fetch,
  output logic            decode_ready,
  input  logic            ex_stall,
  input  logic            ex_flush,
  input  wb_t             wb,
  input  logic            iflush_done,
  input  logic            dflush_done,
  output logic            icache_flush,
  output logic            dcache_flush,
  output decode_execute_t de_out
);

  control_t ctrl;
  imm_t     imm;
  word_t    rs1_data;
  word_t    rs2_data;
  logic     rs1_busy;
  logic     rs2_busy;
  logic     issue;

  // Both decoders look at the raw instruction word
  control_unit u_control_unit (
    .instr (fetch.instr),
    .ctrl  (ctrl)
  );

  imm_gen u_imm_gen (
    .instr (fetch.instr),
    .imm   (imm)
  );

  reg_file u_reg_file (
    .CLK      (CLK),
    .nRST     (nRST),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rs1_busy (rs1_busy),
    .rs2_busy (rs2_busy),
    .issue    (issue),
    .issue_rd (ctrl.rd),
    .wb       (wb)
  );

  dispatch_latch u_dispatch_latch (
    .CLK          (CLK),
    .nRST         (nRST),
    .fetch_valid  (fetch_valid),
    .fetch        (fetch),
    .ctrl         (ctrl),
    .imm          (imm),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .rs1_busy     (rs1_busy),
    .rs2_busy     (rs2_busy),
    .ex_stall     (ex_stall),
    .ex_flush     (ex_flush),
    .iflush_done  (iflush_done),
    .dflush_done  (dflush_done),
    .decode_ready (decode_ready),
    .issue        (issue),
    .icache_flush (icache_flush),
    .dcache_flush (dcache_flush),
    .de_out       (de_out)
  );

endmodule

`default_nettype wire

/* hdl/dispatch_latch.sv */
`timescale 1ns/10ps
`default_nettype none

module dispatch_latch import ooo_decode_pkg::*; (
  input  logic            CLK,
  input  logic            nRST,
  input  logic            fetch_valid,
  input  fetch_decode_t   fetch,
  input  control_t        ctrl,
  input  imm_t            imm,
  input  word_t           rs1_data,
  input  word_t           rs2_data,
  input  logic            rs1_busy,
  input  logic            rs2_busy,
  input  logic            ex_stall,
  input  logic            ex_flush,
  input  logic            iflush_done,
  input  logic            dflush_done,
  output logic            decode_ready,
  output logic            issue,
  output logic            icache_flush,
  output logic            dcache_flush,
  output decode_execute_t de_out
);

  logic            running;
  logic            hazard;
  logic            iflushed;
  logic            dflushed;
  logic            accept;
  logic            keep;
  logic            valid_q;
  cb_idx_t         cb_tail;
  word_t           port_a;
  word_t           port_b;
  word_t           imm_or_shamt;
  decode_execute_t de_next;
  decode_execute_t de_q;

  assign hazard = (ctrl.uses_rs1 & rs1_busy) | (ctrl.uses_rs2 & rs2_busy);

  assign decode_ready = running & ~hazard & iflushed & dflushed & ~ex_stall;
  assign accept       = fetch_valid & decode_ready;
  // Instruction survives into execute
  assign keep         = accept & ~ex_flush;
  assign issue        = keep & ctrl.wen;

  assign imm_or_shamt = ctrl.imm_shamt_sel ? imm.shamt : imm.imm_i;

  always_comb begin
    case (ctrl.src_a_sel)
      SRCA_RS1:   port_a = rs1_data;
      SRCA_IMM_S: port_a = imm.imm_s;
      SRCA_PC:    port_a = fetch.pc;
      default:    port_a = '0;
    endcase
    case (ctrl.src_b_sel)
      SRCB_RS1:   port_b = rs1_data;
      SRCB_RS2:   port_b = rs2_data;
      SRCB_IMM:   port_b = imm_or_shamt;
      default:    port_b = imm.imm_u;
    endcase
  end

  always_comb begin
    de_next                = '0;
    de_next.valid          = 1'b1;
    de_next.sfu_type       = ctrl.sfu_type;
    de_next.alu_op         = ctrl.alu_op;
    de_next.port_a         = port_a;
    de_next.port_b         = port_b;
    de_next.rd             = ctrl.rd;
    de_next.wen            = ctrl.wen;
    de_next.cb_index       = cb_tail;
    de_next.w_src          = ctrl.w_src;
    de_next.reg_file_wdata = (ctrl.w_src == WSRC_PC4)   ? fetch.pc4 :
                             (ctrl.w_src == WSRC_IMM_U) ? imm.imm_u : '0;
    de_next.jump           = ctrl.jump;
    // JAL jumps from pc, JALR from rs1
    de_next.j_base         = ctrl.j_sel ? fetch.pc : rs1_data;
    de_next.j_offset       = ctrl.j_sel ? imm.imm_uj : imm.imm_i;
    de_next.dren           = ctrl.dren;
    de_next.dwen           = ctrl.dwen;
    de_next.byte_en        = ctrl.byte_en;
    de_next.mul_signed     = ctrl.mul_signed;
    de_next.div_signed     = ctrl.div_signed;
    de_next.halt           = ctrl.halt;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      running      <= 1'b0;
      valid_q      <= 1'b0;
      cb_tail      <= '0;
      iflushed     <= 1'b1;
      dflushed     <= 1'b1;
      icache_flush <= 1'b0;
      dcache_flush <= 1'b0;
    end else begin
      running <= 1'b1;
      if (ex_flush) begin
        valid_q <= 1'b0;
      end else if (!ex_stall) begin
        valid_q <= accept;
      end
      // Slot allocated only for instructions that go to execute
      if (keep) begin
        cb_tail <= (cb_tail == cb_idx_t'(CB_DEPTH - 1)) ? '0 : cb_tail + 1'b1;
      end
      icache_flush <= keep & ctrl.ifence;
      dcache_flush <= keep & ctrl.ifence;
      // Fence waits for both caches, done pulses in any order
      if (keep && ctrl.ifence) begin
        iflushed <= 1'b0;
        dflushed <= 1'b0;
      end else begin
        if (iflush_done) iflushed <= 1'b1;
        if (dflush_done) dflushed <= 1'b1;
      end
    end
  end

  // Payload only, qualified by valid_q
  always_ff @(posedge CLK) begin
    if (accept) begin
      de_q <= de_next;
    end
  end

  always_comb begin
    de_out       = de_q;
    de_out.valid = valid_q;
  end

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_file import ooo_decode_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rs1_data,
  output word_t    rs2_data,
  output logic     rs1_busy,
  output logic     rs2_busy,
  input  logic     issue,
  input  reg_idx_t issue_rd,
  input  wb_t      wb
);

  word_t       regs [32];
  logic [31:0] busy;

  // Register storage, x0 never written
  always_ff @(posedge CLK) begin
    if (wb.en && (wb.rd != '0)) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // Scoreboard
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy <= '0;
    end else begin
      if (wb.en) begin
        busy[wb.rd] <= 1'b0;
      end
      // A newly issued producer wins over a retiring one
      if (issue && (issue_rd != '0)) begin
        busy[issue_rd] <= 1'b1;
      end
    end
  end

  // Asynchronous reads, no bypass from a same-cycle writeback
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  assign rs1_busy = busy[rs1];
  assign rs2_busy = busy[rs2];

endmodule

`default_nettype wire

/* hdl/imm_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module imm_gen import ooo_decode_pkg::*; (
  input  word_t instr,
  output imm_t  imm
);

  logic sign;

  // Every format comes from the same sign bit
  assign sign = instr[31];

  // I type, loads, OP-IMM and JALR
  assign imm.imm_i = {{20{sign}}, instr[31:20]};

  // S type, split around rd
  assign imm.imm_s = {{20{sign}}, instr[31:25], instr[11:7]};

  // U type, upper 20 bits
  assign imm.imm_u = {instr[31:12], 12'h000};

  // UJ type for JAL, always even
  assign imm.imm_uj = {
    {11{sign}},
    sign,
    instr[19:12],
    instr[20],
    instr[30:21],
    1'b0
  };

  // Shift amount is never sign-extended
  assign imm.shamt = {27'd0, instr[24:20]};

endmodule

`default_nettype wire

/* hdl/control_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module control_unit import ooo_decode_pkg::*; (
  input  word_t    instr,
  output control_t ctrl
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       alt_op;
  byte_en_t   size_mask;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // Bit 30 picks SUB and SRA, but on OP-IMM only for the right shifts
  assign alt_op = funct7[5] & ((opcode == OP_REG) | (funct3 == 3'b101));

  // Byte lanes from the access size
  always_comb begin
    case (funct3[1:0])
      2'b00:   size_mask = 4'b0001;
      2'b01:   size_mask = 4'b0011;
      default: size_mask = 4'b1111;
    endcase
  end

  function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
    alu_op_t op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    // Non-writing arithmetic no-op unless an opcode below says otherwise
    ctrl           = '0;
    ctrl.sfu_type  = ARITH_S;
    ctrl.alu_op    = ALU_ADD;
    ctrl.src_a_sel = SRCA_RS1;
    ctrl.src_b_sel = SRCB_RS2;
    ctrl.w_src     = WSRC_NONE;
    ctrl.rd        = instr[11:7];
    ctrl.rs1       = instr[19:15];
    ctrl.rs2       = instr[24:20];

    case (opcode)
      OP_LUI: begin
        ctrl.wen       = 1'b1;
        ctrl.src_b_sel = SRCB_IMM_U;
        ctrl.w_src     = WSRC_IMM_U;
      end
      OP_AUIPC: begin
        ctrl.wen       = 1'b1;
        ctrl.src_a_sel = SRCA_PC;
        ctrl.src_b_sel = SRCB_IMM_U;
      end
      OP_JAL: begin
        ctrl.wen   = 1'b1;
        ctrl.w_src = WSRC_PC4;
        ctrl.jump  = 1'b1;
        ctrl.j_sel = 1'b1;
      end
      OP_JALR: begin
        ctrl.wen      = 1'b1;
        ctrl.w_src    = WSRC_PC4;
        ctrl.jump     = 1'b1;
        ctrl.uses_rs1 = 1'b1;
      end
      OP_BRANCH: begin
        ctrl.alu_op   = ALU_SUB;
        ctrl.uses_rs1 = 1'b1;
        ctrl.uses_rs2 = 1'b1;
      end
      OP_LOAD, OP_STORE: begin
        // LSU gets funct3 for width and sign
        ctrl.sfu_type = LOADSTORE_S;
        ctrl.alu_op   = {1'b0, funct3};
        ctrl.byte_en  = size_mask;
        ctrl.uses_rs1 = 1'b1;
        if (opcode == OP_LOAD) begin
          ctrl.src_b_sel = SRCB_IMM;
          ctrl.dren      = 1'b1;
          ctrl.wen       = 1'b1;
        end else begin
          ctrl.src_a_sel = SRCA_IMM_S;
          ctrl.src_b_sel = SRCB_RS1;
          ctrl.dwen      = 1'b1;
          ctrl.uses_rs2  = 1'b1;
        end
      end
      OP_IMM: begin
        ctrl.alu_op        = arith_op(funct3, alt_op);
        ctrl.src_b_sel     = SRCB_IMM;
        ctrl.imm_shamt_sel = (funct3[1:0] == 2'b01);
        ctrl.wen           = 1'b1;
        ctrl.uses_rs1      = 1'b1;
      end
      OP_REG: begin
        ctrl.wen      = 1'b1;
        ctrl.uses_rs1 = 1'b1;
        ctrl.uses_rs2 = 1'b1;
        if (funct7 == 7'b0000001) begin
          ctrl.sfu_type   = funct3[2] ? DIV_S : MUL_S;
          ctrl.alu_op     = {1'b0, funct3};
          ctrl.mul_signed = {funct3[1:0] != 2'b11, ~funct3[1]};
          ctrl.div_signed = ~funct3[0];
        end else begin
          ctrl.alu_op = arith_op(funct3, alt_op);
        end
      end
      OP_MISCMEM: ctrl.ifence = (funct3 == 3'b001);
      OP_SYSTEM:  ctrl.halt   = (funct3 == 3'b000) && (instr[31:20] == 12'h000);
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/ooo_decode_pkg.sv */
`default_nettype none

package ooo_decode_pkg;

  // Completion buffer geometry
  localparam int CB_DEPTH = 8;
  localparam int CB_IDX_W = $clog2(CB_DEPTH);

  typedef logic [31:0]         word_t;
  typedef logic [4:0]          reg_idx_t;
  typedef logic [CB_IDX_W-1:0] cb_idx_t;
  typedef logic [3:0]          alu_op_t;
  typedef logic [3:0]          byte_en_t;
  typedef logic [6:0]          opcode_t;

  // RV32I major opcodes
  localparam opcode_t OP_LUI     = 7'b0110111;
  localparam opcode_t OP_AUIPC   = 7'b0010111;
  localparam opcode_t OP_JAL     = 7'b1101111;
  localparam opcode_t OP_JALR    = 7'b1100111;
  localparam opcode_t OP_BRANCH  = 7'b1100011;
  localparam opcode_t OP_LOAD    = 7'b0000011;
  localparam opcode_t OP_STORE   = 7'b0100011;
  localparam opcode_t OP_IMM     = 7'b0010011;
  localparam opcode_t OP_REG     = 7'b0110011;
  localparam opcode_t OP_MISCMEM = 7'b0001111;
  localparam opcode_t OP_SYSTEM  = 7'b1110011;

  // ALU operations for the arithmetic unit
  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_SLL  = 4'd2;
  localparam alu_op_t ALU_SLT  = 4'd3;
  localparam alu_op_t ALU_SLTU = 4'd4;
  localparam alu_op_t ALU_XOR  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_OR   = 4'd8;
  localparam alu_op_t ALU_AND  = 4'd9;

  typedef enum logic [1:0] {ARITH_S, LOADSTORE_S, MUL_S, DIV_S} sfu_type_t;
  typedef enum logic [1:0] {SRCA_RS1, SRCA_IMM_S, SRCA_PC} src_a_sel_t;
  typedef enum logic [1:0] {SRCB_RS1, SRCB_RS2, SRCB_IMM, SRCB_IMM_U} src_b_sel_t;
  typedef enum logic [1:0] {WSRC_NONE, WSRC_PC4, WSRC_IMM_U} w_src_t;

  typedef struct packed {
    word_t instr;
    word_t pc;
    word_t pc4;
  } fetch_decode_t;

  typedef struct packed {
    sfu_type_t  sfu_type;
    alu_op_t    alu_op;
    src_a_sel_t src_a_sel;
    src_b_sel_t src_b_sel;
    logic       imm_shamt_sel;
    w_src_t     w_src;
    logic       wen;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       jump;
    logic       j_sel;
    logic       ifence;
    logic       halt;
    logic       dren;
    logic       dwen;
    byte_en_t   byte_en;
    logic [1:0] mul_signed;
    logic       div_signed;
  } control_t;

  typedef struct packed {
    word_t imm_i;
    word_t imm_s;
    word_t imm_u;
    word_t imm_uj;
    word_t shamt;
  } imm_t;

  typedef struct packed {
    logic     en;
    reg_idx_t rd;
    word_t    data;
  } wb_t;

  typedef struct packed {
    logic       valid;
    sfu_type_t  sfu_type;
    alu_op_t    alu_op;
    word_t      port_a;
    word_t      port_b;
    reg_idx_t   rd;
    logic       wen;
    cb_idx_t    cb_index;
    w_src_t     w_src;
    word_t      reg_file_wdata;
    logic       jump;
    word_t      j_base;
    word_t      j_offset;
    logic       dren;
    logic       dwen;
    byte_en_t   byte_en;
    logic [1:0] mul_signed;
    logic       div_signed;
    logic       halt;
  } decode_execute_t;

endpackage

`default_nettype wire
